// File: list.f
verilog/stepper_pkg.sv
verilog/stepper_regs.sv
verilog/tick_prescaler.sv
verilog/pwm_generator.sv
verilog/step_sequencer.sv
verilog/step_motor_controller.sv
sim/tb_step_motor_controller.sv

// File: sim/tb_step_motor_controller.sv
// Testbench for the stepper controller covering bus access, coil patterns, steps and PWM
`timescale 1ns/1ps

module tb_step_motor_controller
  import stepper_pkg::*;
();

  // Half-step coil order, b2 b1 a2 a1
  localparam logic [3:0] HALF_SEQ [0:7] = '{4'b1001, 4'b0001, 4'b0011, 4'b0010,
                                             4'b0110, 4'b0100, 4'b1100, 4'b1000};

  logic        clk = 1'b0;
  logic        rst_n;
  logic        wbs_cyc_i, wbs_stb_i, wbs_we_i;
  logic [31:0] wbs_adr_i, wbs_dat_i, wbs_dat_o;
  logic [3:0]  wbs_sel_i;
  logic        wbs_ack_o;
  coil_t       motor_o;

  integer      seed = 32'h7b48_5178;
  logic [31:0] model [0:7];          // Expected register contents
  logic        step_known = 1'b1;    // Countdown not moving
  logic [31:0] exp_rdata = '0;
  logic        rd_chk = 1'b0;
  logic        tracking = 1'b0;      // Coil pattern and sequence checks on
  logic        sh_type = 1'b0;
  logic        sh_mode = 1'b0;
  logic        sh_dir = 1'b0;
  logic [3:0]  last_motor = '0;      // Last nonzero coil value
  int          changes = 0;
  int          exp_changes = 0;
  logic        count_chk = 1'b0;
  logic        count_en = 1'b0;
  logic        duty_chk = 1'b0;
  int          high_cnt = 0;
  int          exp_high = 0;
  logic        en_shadow;            // Enable as written over the bus

  always #5 clk = ~clk;

  step_motor_controller #(.PSIZE(8), .DSIZE(8)) UUT (
    .clk(clk), .rst_n(rst_n),
    .wbs_cyc_i(wbs_cyc_i), .wbs_stb_i(wbs_stb_i), .wbs_we_i(wbs_we_i),
    .wbs_adr_i(wbs_adr_i), .wbs_dat_i(wbs_dat_i), .wbs_sel_i(wbs_sel_i),
    .wbs_dat_o(wbs_dat_o), .wbs_ack_o(wbs_ack_o), .motor_o(motor_o)
  );

  ////////////////////
  // Reference rules
  ////////////////////
  function automatic logic [3:0] wire_map(input logic [3:0] e, input logic bipolar);
    return bipolar ? {e[3], e[1], e[2], e[0]} : e; // Bridge swaps a2 and b1
  endfunction

  function automatic logic coil_ok(input logic [3:0] m, input logic bip, input logic half);
    int   i;
    logic ok;
    ok = 1'b0;
    for (i = 0; i < 8; i++) begin
      if ((half || (i % 2 == 0)) && (wire_map(HALF_SEQ[i], bip) == m)) ok = 1'b1;
    end
    return ok;
  endfunction

  function automatic logic [3:0] next_coil(input logic [3:0] m, input logic bip,
                                           input logic half, input logic dir);
    int         i;
    logic [2:0] idx;
    idx = '0;
    for (i = 0; i < 8; i++) begin
      if (wire_map(HALF_SEQ[i], bip) == m) idx = 3'(i);
    end
    idx = dir ? idx - (half ? 3'd1 : 3'd2) : idx + (half ? 3'd1 : 3'd2);
    return wire_map(HALF_SEQ[idx], bip);
  endfunction

  function automatic logic [31:0] reg_mask(input logic [2:0] r);
    case (r)
      REG_CONFIG:  return 32'hE000_00FF;
      REG_DIVIDER: return 32'h0000_00FF; // 8-bit prescaler
      REG_PERIOD:  return 32'h0000_00FF;
      REG_STEP:    return 32'hE000_FFFF;
      default:     return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] cfg_word(input logic en, input logic bip, input logic half,
                                           input logic [7:0] duty);
    return {en, bip, half, 21'd0, duty};
  endfunction

  function automatic logic [31:0] step_word(input logic run, input logic dir, input logic free,
                                            input logic [15:0] n);
    return {run, dir, free, 13'd0, n};
  endfunction

  task automatic stop_on_failure(input string line);
    $display("%s", line);
    $display("SIMULATION FAILED");
    $fatal(1, "Stopped at the first failure");
  endtask

  ////////////////////
  // Monitors
  ////////////////////
  always @(posedge clk) begin
    if (!tracking) begin
      last_motor <= 4'h0;
      changes    <= 0;
    end else if (motor_o != 4'h0) begin
      if ((last_motor != 4'h0) && (motor_o != last_motor)) changes <= changes + 1;
      last_motor <= motor_o;
    end
    if (count_en && (motor_o != 4'h0)) begin
      high_cnt <= high_cnt + 1;
    end else if (!count_en && !duty_chk) begin
      high_cnt <= 0;                              // Hold the total for the check
    end
    if (!rst_n) begin
      en_shadow <= 1'b0;
    end else if (wbs_cyc_i && wbs_stb_i && wbs_we_i && !wbs_ack_o &&
                 (wbs_adr_i[4:2] == 3'd0) && wbs_sel_i[3]) begin
      en_shadow <= wbs_dat_i[31];
    end
  end

  ack_next_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    (wbs_cyc_i && wbs_stb_i && !wbs_ack_o) |=> wbs_ack_o)
    else stop_on_failure($sformatf("ERROR at %0t: no ack after a request", $time));
  ack_single: assert property (@(posedge clk) disable iff (!rst_n) wbs_ack_o |=> !wbs_ack_o)
    else stop_on_failure($sformatf("ERROR at %0t: ack longer than one cycle", $time));
  read_data: assert property (@(posedge clk) disable iff (!rst_n)
    (wbs_ack_o && rd_chk) |-> (wbs_dat_o == exp_rdata))
    else stop_on_failure($sformatf("ERROR at %0t: read %h, expected %h", $time,
                                   wbs_dat_o, exp_rdata));
  coil_pattern: assert property (@(posedge clk) disable iff (!rst_n)
    (tracking && (motor_o != 4'h0)) |-> coil_ok(motor_o, sh_type, sh_mode))
    else stop_on_failure($sformatf("ERROR at %0t: coil value %b not in table", $time, motor_o));
  coil_order: assert property (@(posedge clk) disable iff (!rst_n)
    (tracking && (motor_o != 4'h0) && (last_motor != 4'h0) && (motor_o != last_motor))
      |-> (motor_o == next_coil(last_motor, sh_type, sh_mode, sh_dir)))
    else stop_on_failure($sformatf("ERROR at %0t: coil %b does not follow %b", $time,
                                   motor_o, last_motor));
  step_total: assert property (@(posedge clk) disable iff (!rst_n)
    count_chk |-> (changes == exp_changes))
    else stop_on_failure($sformatf("ERROR at %0t: %0d steps, expected %0d", $time,
                                   changes, exp_changes));
  duty_total: assert property (@(posedge clk) disable iff (!rst_n)
    duty_chk |-> (high_cnt == exp_high))
    else stop_on_failure($sformatf("ERROR at %0t: %0d coil-on cycles, expected %0d", $time,
                                   high_cnt, exp_high));
  coils_off: assert property (@(posedge clk) disable iff (!rst_n)
    !en_shadow |=> (motor_o == 4'h0))
    else stop_on_failure($sformatf("ERROR at %0t: coils on while disabled", $time));

  ////////////////////
  // Bus and stimulus
  ////////////////////
  task automatic bus_access(input logic [2:0] r, input logic we, input logic [31:0] data,
                            input logic [3:0] sel, output logic [31:0] rdata);
    int          waited;
    logic [31:0] wm;
    wm = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    @(posedge clk);
    wbs_cyc_i <= 1'b1;
    wbs_stb_i <= 1'b1;
    wbs_we_i  <= we;
    wbs_adr_i <= {27'd0, r, 2'b00};
    wbs_dat_i <= data;
    wbs_sel_i <= sel;
    exp_rdata <= model[r];                           // Old value, also on a write
    rd_chk    <= (r != REG_STEP) || step_known;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > 16) stop_on_failure("Timeout: the register slave never acknowledged");
    end while (!wbs_ack_o);
    rdata = wbs_dat_o;
    wbs_cyc_i <= 1'b0;
    wbs_stb_i <= 1'b0;
    wbs_we_i  <= 1'b0;
    rd_chk    <= 1'b0;
    if (we) model[r] = ((model[r] & ~wm) | (data & wm)) & reg_mask(r);
  endtask

  task automatic wb_write(input logic [2:0] r, input logic [31:0] data, input logic [3:0] sel);
    logic [31:0] unused;
    bus_access(r, 1'b1, data, sel, unused);
  endtask

  task automatic wb_read(input logic [2:0] r, output logic [31:0] rdata);
    bus_access(r, 1'b0, 32'h0, 4'h0, rdata);
  endtask

  task automatic wait_changes(input int target);
    int waited;
    waited = 0;
    while (changes < target) begin
      @(posedge clk);
      waited++;
      if (waited > 20000) stop_on_failure("Timeout: the motor stopped stepping");
    end
  endtask

  task automatic measure_duty(input logic [7:0] duty, input logic [1:0] div);
    wb_write(REG_DIVIDER, 32'(div), 4'hF);
    wb_write(REG_CONFIG, cfg_word(1'b1, UNIPOLAR, HALF_STEP, duty), 4'hF);
    repeat (16) @(posedge clk);                      // Let the new divider settle
    exp_high <= (int'(duty) + 1) * (int'(div) + 1);
    count_en <= 1'b1;
    repeat (256 * (int'(div) + 1)) @(posedge clk);   // One full PWM period
    count_en <= 1'b0;
    duty_chk <= 1'b1;
    @(posedge clk);
    duty_chk <= 1'b0;
  endtask

  initial begin
    logic [31:0] rdata;
    logic [31:0] data;
    logic [3:0]  sel;
    logic [2:0]  r;
    int          i;
    rst_n     = 1'b0;
    wbs_cyc_i = 1'b0;
    wbs_stb_i = 1'b0;
    wbs_we_i  = 1'b0;
    wbs_adr_i = '0;
    wbs_dat_i = '0;
    wbs_sel_i = '0;
    for (i = 0; i < 8; i++) model[i] = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // Random writes and readback with the drive chain off
    for (i = 0; i < 24; i++) begin
      r    = 3'($random(seed));
      data = $random(seed);
      sel  = 4'($random(seed));
      if (r == REG_CONFIG) data[31] = 1'b0;
      wb_write(r, data, sel);
      wb_read(r, rdata);
    end
    for (i = 0; i < 8; i++) begin
      wb_read(3'(i), rdata);
    end

    // Every wiring, mode and direction at full duty
    wb_write(REG_DIVIDER, 32'h0, 4'hF);
    wb_write(REG_PERIOD, 32'h0, 4'hF);
    for (i = 0; i < 8; i++) begin
      tracking <= 1'b0;
      wb_write(REG_CONFIG, cfg_word(1'b0, i[2], i[1], 8'hFF), 4'hF);
      wb_write(REG_STEP, step_word(1'b1, i[0], 1'b1, 16'd0), 4'hF);
      {sh_type, sh_mode, sh_dir} = i[2:0];
      wb_write(REG_CONFIG, cfg_word(1'b1, i[2], i[1], 8'hFF), 4'hF);
      tracking <= 1'b1;
      wait_changes(3);
    end

    // Counted steps, then free running
    tracking <= 1'b0;
    wb_write(REG_CONFIG, cfg_word(1'b0, UNIPOLAR, HALF_STEP, 8'hFF), 4'hF);
    wb_write(REG_STEP, step_word(1'b0, 1'b0, 1'b0, 16'd0), 4'hF);
    {sh_type, sh_mode, sh_dir} = 3'b010;
    wb_write(REG_CONFIG, cfg_word(1'b1, UNIPOLAR, HALF_STEP, 8'hFF), 4'hF);
    tracking <= 1'b1;
    wb_write(REG_STEP, step_word(1'b1, 1'b0, 1'b0, 16'd5), 4'hF);
    step_known = 1'b0;
    i = 0;
    do begin
      wb_read(REG_STEP, rdata);
      i++;
      if (i > 4000) stop_on_failure("Timeout: counted steps never cleared the run bit");
    end while (rdata[31]);
    exp_changes <= 6;                                // Cycles 5 gives six steps
    count_chk   <= 1'b1;
    @(posedge clk);
    count_chk <= 1'b0;
    model[REG_STEP] = 32'h0;
    step_known = 1'b1;
    wb_read(REG_STEP, rdata);
    wb_write(REG_STEP, step_word(1'b1, 1'b0, 1'b1, 16'd1), 4'hF);
    step_known = 1'b0;
    wait_changes(10);
    model[REG_STEP] = step_word(1'b1, 1'b0, 1'b1, 16'd0); // Still running at zero
    step_known = 1'b1;
    wb_read(REG_STEP, rdata);

    // PWM duty with stepping stopped
    wb_write(REG_STEP, step_word(1'b0, 1'b0, 1'b0, 16'd0), 4'hF);
    for (i = 0; i < 3; i++) begin
      measure_duty(8'($random(seed)), 2'($random(seed)));
    end

    // Disable drops the coils
    wb_write(REG_CONFIG, cfg_word(1'b0, UNIPOLAR, HALF_STEP, 8'hFF), 4'hF);
    repeat (8) @(posedge clk);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: verilog/pwm_generator.sv
// PWM generator counting ticks into a duty level and a period start pulse
`timescale 1ns/1ps

module pwm_generator
  import stepper_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  enable_i, // Low clears counter and outputs
  input  logic  tick_i,
  input  duty_t duty_i,
  output logic  start_o,  // One cycle per PWM period
  output logic  pwm_o
);

  duty_t count_q;
  logic  start_q;
  logic  pwm_q;

  always_ff @(posedge clk) begin
    if (!rst_n || !enable_i) begin
      count_q <= '0;
      start_q <= 1'b0;
      pwm_q   <= 1'b0;
    end else begin
      if (tick_i) begin
        count_q <= count_q + 1'b1; // Wraps 255 to 0
      end
      start_q <= tick_i && (count_q == 8'hFF);
      pwm_q   <= (count_q <= duty_i); // duty+1 ticks high
    end
  end

  assign start_o = start_q;
  assign pwm_o   = pwm_q;

  start_after_tick: assert property (@(posedge clk) disable iff (!rst_n)
    start_o |-> $past(tick_i))
    else $error("start_o without a tick in the previous cycle");

endmodule

// File: verilog/step_motor_controller.sv
// Stepper motor controller top with Wishbone registers and the coil drive chain
`timescale 1ns/1ps

module step_motor_controller
  import stepper_pkg::*;
#(
  parameter int PSIZE = PSIZE_DEF, // Prescaler width
  parameter int DSIZE = DSIZE_DEF  // Step delay width
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wbs_cyc_i,
  input  logic        wbs_stb_i,
  input  logic        wbs_we_i,
  input  logic [31:0] wbs_adr_i,
  input  logic [31:0] wbs_dat_i,
  input  logic [3:0]  wbs_sel_i,
  output logic [31:0] wbs_dat_o,
  output logic        wbs_ack_o,
  output coil_t       motor_o
);

  logic             enable;
  logic [PSIZE-1:0] divider;
  duty_t            duty;
  logic [DSIZE-1:0] period;
  motor_cfg_t       motor_cfg;
  logic             run;
  logic             step_strobe;
  logic             tick;
  logic             start;
  logic             pwm;

  stepper_regs #(.PSIZE(PSIZE), .DSIZE(DSIZE)) u_regs (
    .clk(clk), .rst_n(rst_n),
    .wbs_cyc_i(wbs_cyc_i), .wbs_stb_i(wbs_stb_i), .wbs_we_i(wbs_we_i),
    .wbs_adr_i(wbs_adr_i), .wbs_dat_i(wbs_dat_i), .wbs_sel_i(wbs_sel_i),
    .wbs_dat_o(wbs_dat_o), .wbs_ack_o(wbs_ack_o),
    .step_strobe_i(step_strobe),
    .enable_o(enable), .divider_o(divider), .duty_o(duty),
    .period_o(period), .motor_cfg_o(motor_cfg), .run_o(run)
  );

  tick_prescaler #(.PSIZE(PSIZE)) u_prescaler (
    .clk(clk), .rst_n(rst_n), .enable_i(enable),
    .divider_i(divider), .tick_o(tick)
  );

  pwm_generator u_pwm (
    .clk(clk), .rst_n(rst_n), .enable_i(enable), .tick_i(tick),
    .duty_i(duty), .start_o(start), .pwm_o(pwm)
  );

  step_sequencer #(.DSIZE(DSIZE)) u_sequencer (
    .clk(clk), .rst_n(rst_n), .enable_i(enable), .run_i(run),
    .period_i(period), .motor_cfg_i(motor_cfg), .start_i(start),
    .pwm_i(pwm), .step_strobe_o(step_strobe), .motor_o(motor_o)
  );

endmodule

// File: verilog/step_sequencer.sv
// Step sequencer timing motor steps and mapping the coil table to the outputs
`timescale 1ns/1ps

module step_sequencer
  import stepper_pkg::*;
#(
  parameter int DSIZE = DSIZE_DEF // Delay counter width
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             enable_i,     // Low clears all state
  input  logic             run_i,
  input  logic [DSIZE-1:0] period_i,     // PWM periods per step, minus one
  input  motor_cfg_t       motor_cfg_i,
  input  logic             start_i,      // PWM period start
  input  logic             pwm_i,
  output logic             step_strobe_o,
  output coil_t            motor_o
);

  logic [DSIZE-1:0] delay_q;
  motor_state_t     state_q;
  logic             strobe_q;
  logic             pwm_d;
  coil_t            motor_q;
  motor_state_t     table_idx;
  coil_t            entry;
  coil_t            mapped;
  logic             step_due;

  assign step_due = run_i && start_i && (delay_q >= period_i);

  ////////////////////
  // Step timing
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n || !enable_i) begin
      delay_q  <= '0;
      state_q  <= '0;
      strobe_q <= 1'b0;
    end else begin
      if (!run_i) begin
        delay_q <= '0;
      end else if (start_i) begin
        if (delay_q < period_i) begin
          delay_q <= delay_q + 1'b1;
        end else begin
          delay_q <= '0;
          if (!motor_cfg_i.direction) begin
            state_q <= state_q + 1'b1; // Forward through the table
          end else begin
            state_q <= state_q - 1'b1;
          end
        end
      end
      strobe_q <= step_due;
    end
  end

  ////////////////////
  // Coil mapping
  ////////////////////
  always_comb begin
    table_idx    = state_q;
    if (motor_cfg_i.drive_mode == FULL_STEP) begin
      table_idx[0] = 1'b0; // Two coils on at every step
    end
    entry  = COIL_TABLE[table_idx];
    mapped = entry;
    if (motor_cfg_i.motor_type == BIPOLAR) begin
      mapped.a2 = entry.b1; // Bridge wiring swaps a2 and b1
      mapped.b1 = entry.a2;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || !enable_i) begin
      pwm_d   <= 1'b0;
      motor_q <= '0;
    end else begin
      pwm_d   <= pwm_i;
      motor_q <= mapped & {4{pwm_d}}; // Coils follow pwm by 2 cycles
    end
  end

  assign step_strobe_o = strobe_q;
  assign motor_o       = motor_q;

  coils_off_when_disabled: assert property (@(posedge clk) disable iff (!rst_n)
    !$past(enable_i, 2) |-> (motor_o == '0))
    else $error("Coils driven two cycles after disable");

endmodule

// File: verilog/stepper_pkg.sv
// Stepper controller shared widths, register map, coil table and types

package stepper_pkg;

  localparam int PSIZE_DEF = 16; // Prescaler counter width
  localparam int DSIZE_DEF = 16; // Step delay counter width

  typedef logic [7:0]  duty_t;        // PWM duty cycle
  typedef logic [15:0] cycles_t;      // Remaining steps
  typedef logic [2:0]  motor_state_t; // Index into the coil table

  typedef struct packed {
    logic b2;
    logic b1;
    logic a2;
    logic a1;
  } coil_t;

  // Half-step sequence, written b2 b1 a2 a1
  localparam coil_t COIL_TABLE [0:7] = '{
    4'b1001,
    4'b0001,
    4'b0011,
    4'b0010,
    4'b0110,
    4'b0100,
    4'b1100,
    4'b1000
  };

  typedef enum logic {UNIPOLAR = 1'b0, BIPOLAR = 1'b1} motor_type_e;
  typedef enum logic {FULL_STEP = 1'b0, HALF_STEP = 1'b1} drive_mode_e;

  typedef enum logic [2:0] {
    REG_CONFIG  = 3'd0,
    REG_DIVIDER = 3'd1,
    REG_PERIOD  = 3'd2,
    REG_STEP    = 3'd3
  } reg_addr_e;

  typedef struct packed {
    motor_type_e motor_type;
    drive_mode_e drive_mode;
    logic        direction;  // 0 counts up the table
  } motor_cfg_t;

  localparam int CONFIG_EN_BIT   = 31;
  localparam int CONFIG_TYPE_BIT = 30;
  localparam int CONFIG_MODE_BIT = 29;
  localparam int STEP_RUN_BIT    = 31;
  localparam int STEP_DIR_BIT    = 30;
  localparam int STEP_FREE_BIT   = 29;

endpackage

// File: verilog/stepper_regs.sv
// Wishbone register slave with configuration, run control and step countdown
`timescale 1ns/1ps

module stepper_regs
  import stepper_pkg::*;
#(
  parameter int PSIZE = PSIZE_DEF, // Prescaler width
  parameter int DSIZE = DSIZE_DEF  // Step delay width
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wbs_cyc_i,
  input  logic             wbs_stb_i,
  input  logic             wbs_we_i,
  input  logic [31:0]      wbs_adr_i,
  input  logic [31:0]      wbs_dat_i,
  input  logic [3:0]       wbs_sel_i,
  output logic [31:0]      wbs_dat_o,
  output logic             wbs_ack_o,
  input  logic             step_strobe_i, // One pulse per motor step
  output logic             enable_o,
  output logic [PSIZE-1:0] divider_o,
  output duty_t            duty_o,
  output logic [DSIZE-1:0] period_o,
  output motor_cfg_t       motor_cfg_o,
  output logic             run_o
);

  logic             req;
  logic             ack_q;
  reg_addr_e        addr;
  logic [31:0]      wmask;
  logic [31:0]      rd_word;
  logic [31:0]      wr_word;
  logic             step_wr;
  logic             enable_q;
  logic [PSIZE-1:0] divider_q;
  duty_t            duty_q;
  logic [DSIZE-1:0] period_q;
  motor_cfg_t       cfg_q;
  logic             run_q;
  logic             free_q;
  cycles_t          cycles_q;

  assign req     = wbs_cyc_i && wbs_stb_i && !ack_q; // New access
  assign addr    = reg_addr_e'(wbs_adr_i[4:2]);
  assign wmask   = {{8{wbs_sel_i[3]}}, {8{wbs_sel_i[2]}}, {8{wbs_sel_i[1]}}, {8{wbs_sel_i[0]}}};
  assign wr_word = (rd_word & ~wmask) | (wbs_dat_i & wmask); // Byte merge
  assign step_wr = req && wbs_we_i && (addr == REG_STEP);

  ////////////////////
  // Readback
  ////////////////////
  always_comb begin
    rd_word = '0;
    case (addr)
      REG_CONFIG: begin
        rd_word[CONFIG_EN_BIT]   = enable_q;
        rd_word[CONFIG_TYPE_BIT] = cfg_q.motor_type;
        rd_word[CONFIG_MODE_BIT] = cfg_q.drive_mode;
        rd_word[7:0]             = duty_q;
      end
      REG_DIVIDER: rd_word = 32'(divider_q); // Upper bits zero
      REG_PERIOD:  rd_word = 32'(period_q);
      REG_STEP: begin
        rd_word[STEP_RUN_BIT]  = run_q;
        rd_word[STEP_DIR_BIT]  = cfg_q.direction;
        rd_word[STEP_FREE_BIT] = free_q;
        rd_word[15:0]          = cycles_q;
      end
      default: rd_word = '0; // Unmapped
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      wbs_dat_o <= rd_word; // Old value on a write
    end
  end

  ////////////////////
  // Write path
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      enable_q  <= 1'b0;
      divider_q <= '0;
      duty_q    <= '0;
      period_q  <= '0;
      cfg_q     <= '{motor_type: UNIPOLAR, drive_mode: FULL_STEP, direction: 1'b0};
      free_q    <= 1'b0;
    end else if (req && wbs_we_i) begin
      case (addr)
        REG_CONFIG: begin
          enable_q         <= wr_word[CONFIG_EN_BIT];
          cfg_q.motor_type <= motor_type_e'(wr_word[CONFIG_TYPE_BIT]);
          cfg_q.drive_mode <= drive_mode_e'(wr_word[CONFIG_MODE_BIT]);
          duty_q           <= wr_word[7:0];
        end
        REG_DIVIDER: divider_q <= wr_word[PSIZE-1:0];
        REG_PERIOD:  period_q  <= wr_word[DSIZE-1:0];
        REG_STEP: begin
          cfg_q.direction <= wr_word[STEP_DIR_BIT]; // Unchanged unless top byte set
          free_q          <= wr_word[STEP_FREE_BIT];
        end
        default: ;
      endcase
    end
  end

  // Run flag and step countdown
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run_q    <= 1'b0;
      cycles_q <= '0;
    end else begin
      if (step_wr && wbs_sel_i[3]) begin
        run_q <= wr_word[STEP_RUN_BIT];
      end else if (step_strobe_i && (cycles_q == '0) && !free_q) begin
        run_q <= 1'b0; // Last counted step done
      end
      if (step_wr) begin
        cycles_q <= wr_word[15:0];
      end else if (step_strobe_i && (cycles_q != '0)) begin
        cycles_q <= cycles_q - 1'b1;
      end
    end
  end

  assign wbs_ack_o   = ack_q;
  assign enable_o    = enable_q;
  assign divider_o   = divider_q;
  assign duty_o      = duty_q;
  assign period_o    = period_q;
  assign motor_cfg_o = cfg_q;
  assign run_o       = run_q;

  ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    wbs_ack_o |=> !wbs_ack_o)
    else $error("wbs_ack_o held for more than one cycle");

endmodule

// File: verilog/tick_prescaler.sv
// Clock divider giving one PWM resolution tick every divider+1 cycles
`timescale 1ns/1ps

module tick_prescaler
  import stepper_pkg::*;
#(
  parameter int PSIZE = PSIZE_DEF // Counter width
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             enable_i,  // Low holds the counter cleared
  input  logic [PSIZE-1:0] divider_i,
  output logic             tick_o
);

  logic [PSIZE-1:0] count_q;
  logic             tick_q;

  always_ff @(posedge clk) begin
    if (!rst_n || !enable_i) begin
      count_q <= '0;
      tick_q  <= 1'b0;
    end else if (count_q >= divider_i) begin
      count_q <= '0;   // Also catches a divider lowered on the fly
      tick_q  <= 1'b1;
    end else begin
      count_q <= count_q + 1'b1;
      tick_q  <= 1'b0;
    end
  end

  assign tick_o = tick_q;

endmodule
